// File: rtl/core_shell_pkg.sv
/*
  Shared geometry and key definitions for the core shell.
  Cache widths assume a 2-way cache with 16 lines per bank and no integrity bits.
  The register data width and count are module parameters, not set here.
*/
`default_nettype none

package core_shell_pkg;

  //////////////////////////////////////////////////
  // Instruction cache geometry
  //////////////////////////////////////////////////

  localparam int unsigned NUM_WAYS  = 2;
  localparam int unsigned NUM_LINES = 16;
  localparam int unsigned INDEX_W   = $clog2(NUM_LINES);

  // Tag entry holds the tag plus its valid bit
  localparam int unsigned TAG_W  = 22;
  localparam int unsigned LINE_W = 64;

  //////////////////////////////////////////////////
  // Scrambling
  //////////////////////////////////////////////////

  localparam int unsigned KEY_W   = 64;
  localparam int unsigned NONCE_W = 32;

  // Key and nonce in use until the first rekey completes
  localparam logic [KEY_W-1:0]   KEY_DEFAULT   = 64'hA5C3_1E9F_D2B7_4068;
  localparam logic [NONCE_W-1:0] NONCE_DEFAULT = 32'h3C6E_F372;

  //////////////////////////////////////////////////
  // Payload types
  //////////////////////////////////////////////////

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [LINE_W-1:0] line_t;

  // Register index, always 5 bits even for the reduced register set
  typedef logic [4:0] reg_addr_t;

endpackage

`default_nettype wire

// File: rtl/sleep_ctrl.sv
/*
  Main clock gate and sleep indication.
  Busy is taken one cycle late; debug and interrupt inputs wake the clock at once.
  test_en_i forces the gated clock on for scan.
*/
`timescale 1ns/1ps
`default_nettype none

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic gated_clk_o,
  output logic core_sleep_o
);

  logic busy_q;
  logic clock_en;
  logic en_latch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_i;
    end
  end

  assign clock_en     = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  // Enable latch, open while the clock is low so the gate cannot glitch
  always_latch begin
    if (!clk_i) begin
      en_latch = clock_en | test_en_i;
    end
  end

  assign gated_clk_o = clk_i & en_latch;

endmodule

`default_nettype wire

// File: rtl/register_file_ff.sv
/*
  Flip-flop register file, two read ports and one write port.
  Clocked by the gated core clock, so writes while gated off are dropped.
  Register zero reads zero; reads at or above NumRegs also return zero.
*/
`timescale 1ns/1ps
`default_nettype none

module register_file_ff import core_shell_pkg::*; #(
  parameter int unsigned NumRegs   = 32,
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  reg_addr_t            raddr_a_i,
  input  reg_addr_t            raddr_b_i,
  input  reg_addr_t            waddr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic                 we_i,
  output logic [DataWidth-1:0] rdata_a_o,
  output logic [DataWidth-1:0] rdata_b_o
);

  localparam int unsigned IdxW = $clog2(NumRegs);

  logic [DataWidth-1:0] rf_reg [NumRegs];
  logic [NumRegs-1:1]   we_dec;

  //////////////////////////////////////////////////
  // Write address decode
  //////////////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = we_i && (waddr_i == reg_addr_t'(i));
    end
  end

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // x0 is constant and never written
  assign rf_reg[0] = '0;

  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg[i] <= wdata_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Upper index bits only matter for the reduced register set
  always_comb begin
    if (32'(raddr_a_i) < NumRegs) begin
      rdata_a_o = rf_reg[raddr_a_i[IdxW-1:0]];
    end else begin
      rdata_a_o = '0;
    end
  end

  always_comb begin
    if (32'(raddr_b_i) < NumRegs) begin
      rdata_b_o = rf_reg[raddr_b_i[IdxW-1:0]];
    end else begin
      rdata_b_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/scramble_key_ctrl.sv
/*
  Scramble key request tracking with key and nonce registers.
  A key request drops key valid and raises scramble_req_o until the key source answers.
  Requests arriving while one is pending are absorbed. No back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module scramble_key_ctrl import core_shell_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               key_req_i,
  input  logic               scramble_key_valid_i,
  input  logic [KEY_W-1:0]   scramble_key_i,
  input  logic [NONCE_W-1:0] scramble_nonce_i,
  output logic               key_valid_o,
  output logic [KEY_W-1:0]   key_o,
  output logic [NONCE_W-1:0] nonce_o,
  output logic               scramble_req_o
);

  logic key_valid_d, key_valid_q;
  logic req_d, req_q;

  //////////////////////////////////////////////////
  // Request and valid flags
  //////////////////////////////////////////////////

  // Pending request waits for the key source, otherwise a new request opens one
  assign req_d = req_q ? ~scramble_key_valid_i : key_req_i;

  // Key stays invalid from the request until the new key arrives
  assign key_valid_d = req_q     ? scramble_key_valid_i :
                       key_req_i ? 1'b0                 :
                                   key_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  //////////////////////////////////////////////////
  // Key and nonce
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_o   <= KEY_DEFAULT;
      nonce_o <= NONCE_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_o   <= scramble_key_i;
      nonce_o <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;

endmodule

`default_nettype wire

// File: rtl/scrambled_ram_1p.sv
/*
  Single-port RAM that stores entries XORed with a key/nonce/index keystream.
  Payloads up to 128 bits wide. Data is lost on rekey unless rewritten.
  Requests while the key is invalid are dropped and rdata_o holds.
*/
`timescale 1ns/1ps
`default_nettype none

module scrambled_ram_1p import core_shell_pkg::*; #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned Depth     = NUM_LINES
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     key_valid_i,
  input  logic [KEY_W-1:0]         key_i,
  input  logic [NONCE_W-1:0]       nonce_i,
  input  logic                     req_i,
  input  logic                     write_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  payload_t                 wdata_i,
  output payload_t                 rdata_o
);

  localparam int unsigned AddrW = $clog2(Depth);
  localparam int unsigned Width = $bits(payload_t);

  payload_t          mem_q [Depth];
  logic [KEY_W-1:0]  seed;
  logic [KEY_W-1:0]  mix;
  logic [Width-1:0]  keystream;
  logic              access;

  //////////////////////////////////////////////////
  // Keystream
  //////////////////////////////////////////////////

  // Key and nonce folded, then rotated by the index so each entry differs
  assign seed = key_i ^ {2{nonce_i}} ^ {(KEY_W / 8){8'(addr_i)}};
  assign mix  = (seed << addr_i) | (seed >> (KEY_W - AddrW'(addr_i)));

  // Wide payloads repeat the mixed key
  always_comb begin
    for (int unsigned i = 0; i < Width; i++) begin
      keystream[i] = mix[i % KEY_W];
    end
  end

  assign access = req_i & key_valid_i;

  //////////////////////////////////////////////////
  // Storage and read register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (access && write_i) begin
      mem_q[addr_i] <= wdata_i ^ payload_t'(keystream);
    end
  end

  // Holds the last read between requests
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (access && !write_i) begin
      rdata_o <= mem_q[addr_i] ^ payload_t'(keystream);
    end
  end

endmodule

`default_nettype wire

// File: rtl/core_shell_top.sv
/*
  Core wrapper without the core: clock gate, register file, key control
  and the per-way instruction-cache banks. The core's side of every block
  is exposed at the ports. Only the register file runs on the gated clock.
*/
`timescale 1ns/1ps
`default_nettype none

module core_shell_top import core_shell_pkg::*; #(
  parameter int unsigned NumRegs      = 32,
  parameter int unsigned RegDataWidth = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        test_en_i,

  // Sleep control
  input  logic                        busy_i,
  input  logic                        debug_req_i,
  input  logic                        irq_pending_i,
  input  logic                        irq_nm_i,
  output logic                        core_sleep_o,

  // Register file
  input  reg_addr_t                   raddr_a_i,
  input  reg_addr_t                   raddr_b_i,
  input  reg_addr_t                   waddr_i,
  input  logic [RegDataWidth-1:0]     wdata_i,
  input  logic                        we_i,
  output logic [RegDataWidth-1:0]     rdata_a_o,
  output logic [RegDataWidth-1:0]     rdata_b_o,

  // Scramble key
  input  logic                        key_req_i,
  input  logic                        scramble_key_valid_i,
  input  logic [KEY_W-1:0]            scramble_key_i,
  input  logic [NONCE_W-1:0]          scramble_nonce_i,
  output logic                        scramble_req_o,

  // Tag banks
  input  logic [NUM_WAYS-1:0]         tag_req_i,
  input  logic                        tag_write_i,
  input  logic [INDEX_W-1:0]          tag_addr_i,
  input  tag_t                        tag_wdata_i,
  output tag_t  [NUM_WAYS-1:0]        tag_rdata_o,

  // Data banks
  input  logic [NUM_WAYS-1:0]         data_req_i,
  input  logic                        data_write_i,
  input  logic [INDEX_W-1:0]          data_addr_i,
  input  line_t                       data_wdata_i,
  output line_t [NUM_WAYS-1:0]        data_rdata_o
);

  logic               gated_clk;
  logic               key_valid;
  logic [KEY_W-1:0]   key;
  logic [NONCE_W-1:0] nonce;

  //////////////////////////////////////////////////
  // Main clock gate
  //////////////////////////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .busy_i        (busy_i),
    .debug_req_i   (debug_req_i),
    .irq_pending_i (irq_pending_i),
    .irq_nm_i      (irq_nm_i),
    .gated_clk_o   (gated_clk),
    .core_sleep_o  (core_sleep_o)
  );

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  register_file_ff #(
    .NumRegs   (NumRegs),
    .DataWidth (RegDataWidth)
  ) u_register_file (
    .clk_i     (gated_clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a_i),
    .raddr_b_i (raddr_b_i),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i),
    .we_i      (we_i),
    .rdata_a_o (rdata_a_o),
    .rdata_b_o (rdata_b_o)
  );

  //////////////////////////////////////////////////
  // Scramble key
  //////////////////////////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .key_req_i            (key_req_i),
    .scramble_key_valid_i (scramble_key_valid_i),
    .scramble_key_i       (scramble_key_i),
    .scramble_nonce_i     (scramble_nonce_i),
    .key_valid_o          (key_valid),
    .key_o                (key),
    .nonce_o              (nonce),
    .scramble_req_o       (scramble_req_o)
  );

  //////////////////////////////////////////////////
  // Cache banks, one tag and one data per way
  //////////////////////////////////////////////////

  for (genvar way = 0; way < NUM_WAYS; way++) begin : gen_ways
    scrambled_ram_1p #(
      .payload_t (tag_t),
      .Depth     (NUM_LINES)
    ) u_tag_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .key_valid_i (key_valid),
      .key_i       (key),
      .nonce_i     (nonce),
      .req_i       (tag_req_i[way]),
      .write_i     (tag_write_i),
      .addr_i      (tag_addr_i),
      .wdata_i     (tag_wdata_i),
      .rdata_o     (tag_rdata_o[way])
    );

    scrambled_ram_1p #(
      .payload_t (line_t),
      .Depth     (NUM_LINES)
    ) u_data_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .key_valid_i (key_valid),
      .key_i       (key),
      .nonce_i     (nonce),
      .req_i       (data_req_i[way]),
      .write_i     (data_write_i),
      .addr_i      (data_addr_i),
      .wdata_i     (data_wdata_i),
      .rdata_o     (data_rdata_o[way])
    );
  end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
/*
  Free-running testbench clock and power-on reset.
  Reset is released on a falling edge, away from the sampling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/core_shell_tb.sv
/*
  Testbench for the core shell, standing in for the core and the key source.
  Models are updated on the DUT's own edges; concurrent assertions compare every cycle.
  Bank contents are rewritten after each rekey before they are read back.
*/
`timescale 1ns/1ps
`default_nettype none

module core_shell_tb import core_shell_pkg::*; ();

  localparam int unsigned NUM_REGS    = 32;
  localparam int unsigned REG_W       = 32;
  localparam int unsigned SLEEP_LEN   = 100;
  localparam int unsigned RF_OPS      = 64;
  localparam int unsigned KEY_ROUNDS  = 4;
  localparam int unsigned MAX_DELAY   = 16;
  localparam int unsigned PASS_LEN    = 2 * NUM_WAYS * NUM_LINES + 6;
  localparam int unsigned TEST_LEN    = 10 + SLEEP_LEN + (RF_OPS + 10)
                                      + KEY_ROUNDS * (MAX_DELAY + 6)
                                      + 2 * PASS_LEN + MAX_DELAY + 12;
  localparam int unsigned CYCLE_LIMIT = 2 * TEST_LEN;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic                 clk, rst_n;
  logic                 test_en, busy, debug_req, irq_pending, irq_nm, core_sleep;
  reg_addr_t            raddr_a, raddr_b, waddr;
  logic [REG_W-1:0]     wdata, rdata_a, rdata_b, rf_exp_a, rf_exp_b;
  logic                 we;
  logic                 key_req, key_valid_in, scramble_req;
  logic [KEY_W-1:0]     key_in;
  logic [NONCE_W-1:0]   nonce_in;
  logic [NUM_WAYS-1:0]  tag_req, data_req;
  logic                 tag_write, data_write;
  logic [INDEX_W-1:0]   tag_addr, data_addr;
  tag_t                 tag_wdata;
  line_t                data_wdata;
  tag_t [NUM_WAYS-1:0]  tag_rdata, tag_exp;
  line_t [NUM_WAYS-1:0] data_rdata, data_exp;

  // Reference state
  logic [REG_W-1:0] rf_model [NUM_REGS];
  tag_t             tag_model [NUM_WAYS][NUM_LINES];
  line_t            line_model [NUM_WAYS][NUM_LINES];
  logic             busy_prev, key_valid_model, check_reset;
  logic [31:0]      lfsr_state;
  int               errors, test_start_errors, tests_done, tests_failed;
  int unsigned      cycles = 0;

  tb_clk_gen #(.PeriodNs(20), .ResetCycles(5)) u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  core_shell_top #(.NumRegs(NUM_REGS), .RegDataWidth(REG_W)) uut (
    .clk_i(clk), .rst_ni(rst_n), .test_en_i(test_en), .busy_i(busy),
    .debug_req_i(debug_req), .irq_pending_i(irq_pending), .irq_nm_i(irq_nm),
    .core_sleep_o(core_sleep), .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
    .waddr_i(waddr), .wdata_i(wdata), .we_i(we), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
    .key_req_i(key_req), .scramble_key_valid_i(key_valid_in), .scramble_key_i(key_in),
    .scramble_nonce_i(nonce_in), .scramble_req_o(scramble_req),
    .tag_req_i(tag_req), .tag_write_i(tag_write), .tag_addr_i(tag_addr),
    .tag_wdata_i(tag_wdata), .tag_rdata_o(tag_rdata),
    .data_req_i(data_req), .data_write_i(data_write), .data_addr_i(data_addr),
    .data_wdata_i(data_wdata), .data_rdata_o(data_rdata)
  );

  //////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////

  function automatic logic [REG_W-1:0] rf_expect(reg_addr_t addr);
    if (addr == '0 || 32'(addr) >= NUM_REGS) begin
      return '0;
    end
    return rf_model[addr];
  endfunction

  always_comb begin
    rf_exp_a = rf_expect(raddr_a);
    rf_exp_b = rf_expect(raddr_b);
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_prev       <= 1'b0;
      key_valid_model <= 1'b1;
      tag_exp         <= '0;
      data_exp        <= '0;
      for (int r = 0; r < NUM_REGS; r++) begin
        rf_model[r] <= '0;
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int l = 0; l < NUM_LINES; l++) begin
          tag_model[w][l]  <= '0;
          line_model[w][l] <= '0;
        end
      end
    end else begin
      busy_prev <= busy;
      if (key_req) begin
        key_valid_model <= 1'b0;
      end else if (key_valid_in) begin
        key_valid_model <= 1'b1;
      end
      // Gated clock runs when last cycle's busy or any wake input is high
      if (we && waddr != '0 && (busy_prev | debug_req | irq_pending | irq_nm | test_en)) begin
        rf_model[waddr] <= wdata;
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (key_valid_model && tag_req[w] && tag_write) begin
          tag_model[w][tag_addr] <= tag_wdata;
        end else if (key_valid_model && tag_req[w]) begin
          tag_exp[w] <= tag_model[w][tag_addr];
        end
        if (key_valid_model && data_req[w] && data_write) begin
          line_model[w][data_addr] <= data_wdata;
        end else if (key_valid_model && data_req[w]) begin
          data_exp[w] <= line_model[w][data_addr];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic flag_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
      !check_reset || (!scramble_req && core_sleep))
    else flag_error("scramble request high or core awake after reset");
  a_sleep_rule: assert property (@(posedge clk) disable iff (!rst_n)
      core_sleep == !($past(busy) | debug_req | irq_pending | irq_nm))
    else flag_error("core_sleep_o does not follow the wake inputs");
  a_rf_read: assert property (@(posedge clk) disable iff (!rst_n)
      rdata_a == rf_exp_a && rdata_b == rf_exp_b)
    else flag_error("register read data differs from model");
  a_rf_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (raddr_a != '0 || rdata_a == '0) && (raddr_b != '0 || rdata_b == '0))
    else flag_error("register zero reads nonzero");
  a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
      !($past(key_req) && !$past(scramble_req)) || scramble_req)
    else flag_error("scramble_req_o did not rise after key request");
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !($past(scramble_req) && !$past(key_valid_in)) || scramble_req)
    else flag_error("scramble_req_o dropped before key valid");
  a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
      !$past(key_valid_in) || !scramble_req)
    else flag_error("scramble_req_o still high after key valid");
  a_banks: assert property (@(posedge clk) disable iff (!rst_n)
      tag_rdata == tag_exp && data_rdata == data_exp)
    else flag_error("cache bank read data differs from model");

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] take_bits(int unsigned n);
    logic [63:0] value;
    logic        bit_out;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      bit_out    = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (bit_out ? LFSR_TAPS : 32'h0);
      value[i]   = bit_out;
    end
    return value;
  endfunction

  task automatic end_test(input string name);
    tests_done++;
    if (errors == test_start_errors) begin
      $display("%-14s ok", name);
    end else begin
      tests_failed++;
      $display("%-14s %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  task automatic rekey(input int unsigned delay, input logic while_pending);
    @(posedge clk);
    key_req <= 1'b1;
    @(posedge clk);
    key_req <= 1'b0;
    // Key source answers only once it sees the request
    @(negedge clk);
    while (!scramble_req) begin
      @(negedge clk);
    end
    @(posedge clk);
    if (while_pending) begin
      key_req    <= 1'b1;
      tag_req    <= '1;
      data_req   <= '1;
      tag_write  <= 1'b0;
      data_write <= 1'b0;
      tag_addr   <= INDEX_W'(take_bits(INDEX_W));
      data_addr  <= INDEX_W'(take_bits(INDEX_W));
    end
    repeat (delay) begin
      @(posedge clk);
      key_req  <= 1'b0;
      tag_req  <= '0;
      data_req <= '0;
    end
    key_valid_in <= 1'b1;
    key_in       <= take_bits(KEY_W);
    nonce_in     <= NONCE_W'(take_bits(NONCE_W));
    @(posedge clk);
    key_valid_in <= 1'b0;
    @(negedge clk);
    while (scramble_req) begin
      @(negedge clk);
    end
  endtask

  // Writes every line of both ways, then reads them all back
  task automatic fill_and_check();
    logic [NUM_WAYS-1:0] sel;
    for (int pass = 0; pass < 2; pass++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int a = 0; a < NUM_LINES; a++) begin
          sel    = '0;
          sel[w] = 1'b1;
          @(posedge clk);
          tag_req    <= sel;
          data_req   <= sel;
          tag_write  <= (pass == 0);
          data_write <= (pass == 0);
          tag_addr   <= INDEX_W'(a);
          data_addr  <= INDEX_W'(NUM_LINES - 1 - a);
          tag_wdata  <= tag_t'(take_bits(TAG_W));
          data_wdata <= line_t'(take_bits(LINE_W));
        end
      end
    end
    @(posedge clk);
    tag_req  <= '0;
    data_req <= '0;
    @(posedge clk);
  endtask

  initial begin
    int unsigned last_waddr;
    lfsr_state = 32'd78;
    errors = 0;
    test_start_errors = 0;
    tests_done = 0;
    tests_failed = 0;
    check_reset = 1'b1;
    {test_en, busy, debug_req, irq_pending, irq_nm, we, key_req, key_valid_in} = '0;
    {raddr_a, raddr_b, waddr, wdata, key_in, nonce_in} = '0;
    {tag_req, data_req, tag_write, data_write, tag_addr, data_addr} = '0;
    tag_wdata = '0;
    data_wdata = '0;
    last_waddr = 0;
    @(posedge rst_n);

    repeat (3) @(posedge clk);
    check_reset <= 1'b0;
    end_test("reset state");

    repeat (SLEEP_LEN) begin
      @(posedge clk);
      busy        <= 1'(take_bits(1));
      debug_req   <= 1'(take_bits(1));
      irq_pending <= 1'(take_bits(1));
      irq_nm      <= 1'(take_bits(1));
    end
    @(posedge clk);
    {busy, debug_req, irq_pending, irq_nm} <= '0;
    @(posedge clk);
    end_test("sleep rule");

    busy <= 1'b1;
    @(posedge clk);
    repeat (RF_OPS) begin
      @(posedge clk);
      we         <= 1'b1;
      waddr      <= reg_addr_t'(take_bits(5));
      wdata      <= REG_W'(take_bits(REG_W));
      raddr_a    <= reg_addr_t'(take_bits(5));
      raddr_b    <= reg_addr_t'(last_waddr);
      last_waddr = 32'(waddr);
    end
    // A write to x0 must not stick
    @(posedge clk);
    waddr   <= '0;
    wdata   <= REG_W'(take_bits(REG_W));
    raddr_a <= '0;
    // Clock gated off, so this write must be lost
    @(posedge clk);
    we   <= 1'b0;
    busy <= 1'b0;
    repeat (2) @(posedge clk);
    we      <= 1'b1;
    waddr   <= 5'd7;
    wdata   <= REG_W'(take_bits(REG_W));
    raddr_a <= 5'd7;
    raddr_b <= 5'd0;
    @(posedge clk);
    we <= 1'b0;
    repeat (2) @(posedge clk);
    end_test("register file");

    fill_and_check();
    rekey(32'(take_bits(4)) + 1, 1'b1);
    fill_and_check();
    end_test("cache banks");

    for (int r = 0; r < KEY_ROUNDS; r++) begin
      rekey(32'(take_bits(4)) + 1, r == 1);
    end
    end_test("key protocol");

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_done, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
rtl/core_shell_pkg.sv
rtl/sleep_ctrl.sv
rtl/register_file_ff.sv
rtl/scramble_key_ctrl.sv
rtl/scrambled_ram_1p.sv
rtl/core_shell_top.sv
testbench/tb_clk_gen.sv
testbench/core_shell_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the core shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module core_shell_tb -o core_shell_sim

output=$(./obj_dir/core_shell_sim)
echo "$output"

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
else
  exit 1
fi
